// File: src.f
+incdir+logic
logic/freq_meas_pkg.sv
logic/freq_regs_pkg.sv
logic/refclk_edge_sampler.sv
logic/freq_window_counter.sv
logic/freq_csr_axil.sv
logic/freq_monitor_top.sv
test/freq_monitor_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the frequency monitor testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module freq_monitor_tb \
	-f src.f -o freq_monitor_sim \
	&& ./obj_dir/freq_monitor_sim > sim.log 2>&1
grep -qx "TEST RESULT: PASS" sim.log 2>/dev/null \
	&& { echo "simulation passed"; exit 0; } \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// File: test/freq_monitor_tb.sv
////////////////////////////////////////////////////////////////////////////
// Frequency monitor testbench with AXI4-Lite bus tasks and a reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "freq_settings.svh"

module freq_monitor_tb;

	import freq_meas_pkg::*;
	import freq_regs_pkg::*;

	// eight trials of up to three windows of at most 2 * 20 * 32 cycles each,
	// plus the reset, bus, disable and interrupt tests, with a wide margin
	localparam int num_trials = 8;
	localparam int cycle_limit = 60000;

	logic                      xcvr_clk;
	logic                      rst;
	logic                      refclk;
	axil_addr_t                awaddr;
	logic                      awvalid;
	logic                      awready;
	axil_data_t                wdata;
	logic [`AXIL_DATA_W/8-1:0] wstrb;
	logic                      wvalid;
	logic                      wready;
	axil_resp_t                bresp;
	logic                      bvalid;
	logic                      bready;
	axil_addr_t                araddr;
	logic                      arvalid;
	logic                      arready;
	axil_data_t                rdata;
	axil_resp_t                rresp;
	logic                      rvalid;
	logic                      rready;
	logic                      meas_irq;

	int seed = 32'h7b6f;
	int errors = 0;
	int checks = 0;
	int cycle_cnt = 0;
	// refclk half period in xcvr_clk cycles
	int half_period = 4;
	int ref_cnt = 0;

	freq_monitor_top uut (
		.xcvr_clk (xcvr_clk),
		.rst      (rst),
		.refclk   (refclk),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wstrb    (wstrb),
		.wvalid   (wvalid),
		.wready   (wready),
		.bresp    (bresp),
		.bvalid   (bvalid),
		.bready   (bready),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.rready   (rready),
		.meas_irq (meas_irq)
	);

	initial begin
		xcvr_clk = 1'b0;
		forever #4 xcvr_clk = ~xcvr_clk;
	end

	// refclk toggles every half_period cycles, so rising edges are exactly
	// 2 * half_period cycles apart once the period has settled
	always @(posedge xcvr_clk) begin
		#1;
		if (ref_cnt >= half_period - 1) begin
			ref_cnt = 0;
			refclk = ~refclk;
		end else begin
			ref_cnt = ref_cnt + 1;
		end
	end

	// watchdog so that a DUT which never answers cannot hang the run
	initial begin
		while (cycle_cnt < cycle_limit) begin
			@(posedge xcvr_clk);
			cycle_cnt = cycle_cnt + 1;
		end
		$display("timeout: the DUT did not finish the tests within %0d cycles", cycle_limit);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic pick_range(input int lo, input int hi, output int val);
		val = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endtask

	task automatic check_count(input string name, input meas_count_t got,
		input meas_count_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input axil_data_t got, input axil_data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %s, expected %s", $time, name, got.name(),
				exp.name());
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// bytes with a low strobe keep the old value, only FREQ_CNT_W bits exist
	function automatic axil_data_t strobe_merge(input axil_data_t old_word,
		input axil_data_t new_word, input logic [`AXIL_DATA_W/8-1:0] strb);
		axil_data_t merged;
		merged = old_word;
		for (int i = 0; i < `AXIL_DATA_W / 8; i++) begin
			if (strb[i]) begin
				merged[i*8 +: 8] = new_word[i*8 +: 8];
			end
		end
		return merged & axil_data_t'({`FREQ_CNT_W{1'b1}});
	endfunction

	// ready signals are sampled on the falling edge, where they are settled
	task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
		input logic [`AXIL_DATA_W/8-1:0] strb, output axil_resp_t resp);
		int delay;
		@(posedge xcvr_clk);
		#1;
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		do begin
			@(negedge xcvr_clk);
		end while (!awready);
		// address and data are taken in the same cycle
		check_flag("wready", wready, 1'b1);
		@(posedge xcvr_clk);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		// hold off the response for a few cycles to test back-pressure
		pick_range(0, 3, delay);
		repeat (delay) begin
			@(posedge xcvr_clk);
			#1;
		end
		bready = 1'b1;
		do begin
			@(negedge xcvr_clk);
		end while (!bvalid);
		resp = bresp;
		@(posedge xcvr_clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
		output axil_resp_t resp);
		int delay;
		@(posedge xcvr_clk);
		#1;
		araddr  = addr;
		arvalid = 1'b1;
		do begin
			@(negedge xcvr_clk);
		end while (!arready);
		@(posedge xcvr_clk);
		#1;
		arvalid = 1'b0;
		pick_range(0, 3, delay);
		repeat (delay) begin
			@(posedge xcvr_clk);
			#1;
		end
		rready = 1'b1;
		do begin
			@(negedge xcvr_clk);
		end while (!rvalid);
		data = rdata;
		resp = rresp;
		@(posedge xcvr_clk);
		#1;
		rready = 1'b0;
	endtask

	task automatic write_expect(input axil_addr_t addr, input axil_data_t data,
		input logic [`AXIL_DATA_W/8-1:0] strb, input axil_resp_t exp_resp, input string name);
		axil_resp_t resp;
		axil_write(addr, data, strb, resp);
		check_resp({name, " bresp"}, resp, exp_resp);
	endtask

	task automatic read_expect(input axil_addr_t addr, input axil_data_t exp_data,
		input axil_resp_t exp_resp, input string name);
		axil_data_t data;
		axil_resp_t resp;
		axil_read(addr, data, resp);
		check_word(name, data, exp_data);
		check_resp({name, " rresp"}, resp, exp_resp);
	endtask

	// poll status until a window has closed, the read also clears done
	task automatic wait_done(output axil_data_t status);
		axil_resp_t resp;
		do begin
			axil_read(reg_status, status, resp);
			check_resp("status rresp", resp, resp_okay);
		end while (!status[stat_done_bit]);
	endtask

	initial begin
		axil_data_t                rd;
		axil_data_t                wd;
		axil_data_t                model_lo;
		axil_resp_t                resp;
		logic [`AXIL_DATA_W/8-1:0] strb;
		int                        d;
		int                        wl;
		int                        mode;
		int                        pick;
		meas_count_t               exp_cnt;
		meas_count_t               lo;
		meas_count_t               hi;
		logic                      exp_in;

		rst     = 1'b1;
		refclk  = 1'b0;
		awaddr  = '0;
		awvalid = 1'b0;
		wdata   = '0;
		wstrb   = '0;
		wvalid  = 1'b0;
		bready  = 1'b0;
		araddr  = '0;
		arvalid = 1'b0;
		rready  = 1'b0;
		exp_cnt = '0;
		exp_in  = 1'b0;
		repeat (5) @(posedge xcvr_clk);
		#1;
		rst = 1'b0;

		// every register holds its reset value
		read_expect(reg_ctrl, 32'h0, resp_okay, "ctrl");
		read_expect(reg_window, axil_data_t'(`FREQ_WIN_DEFAULT), resp_okay, "window");
		read_expect(reg_limit_lo, 32'h0, resp_okay, "limit_lo");
		read_expect(reg_limit_hi, axil_data_t'({`FREQ_CNT_W{1'b1}}), resp_okay, "limit_hi");
		read_expect(reg_status, 32'h0, resp_okay, "status");
		read_expect(reg_result, 32'h0, resp_okay, "result");
		check_flag("meas_irq", meas_irq, 1'b0);

		// random strobes on limit_lo, checked against the byte lane model
		model_lo = '0;
		for (int i = 0; i < 4; i++) begin
			wd   = $random(seed);
			strb = wd[`AXIL_DATA_W/8-1:0];
			wd   = $random(seed);
			write_expect(reg_limit_lo, wd, strb, resp_okay, "limit_lo write");
			model_lo = strobe_merge(model_lo, wd, strb);
			read_expect(reg_limit_lo, model_lo, resp_okay, "limit_lo");
		end

		// unmapped offsets give slverr, read zero and change nothing
		write_expect(8'h18, 32'hdeadbeef, 4'hf, resp_slverr, "unmapped write");
		write_expect(8'h40, 32'h12345678, 4'hf, resp_slverr, "unmapped write");
		read_expect(8'h18, 32'h0, resp_slverr, "unmapped read");
		read_expect(8'hfc, 32'h0, resp_slverr, "unmapped read");
		read_expect(reg_limit_lo, model_lo, resp_okay, "limit_lo");

		for (int t = 0; t < num_trials; t++) begin
			pick_range(2, 20, d);
			pick_range(1, 32, wl);
			pick_range(0, 2, mode);
			pick_range(0, 3, pick);
			exp_cnt = meas_count_t'(2 * d * wl);
			// limits below, around or above the expected count
			case (mode)
				0: begin
					hi = exp_cnt - meas_count_t'(1 + pick);
					lo = hi >> 1;
				end
				1: begin
					lo = exp_cnt - meas_count_t'(pick);
					hi = exp_cnt + meas_count_t'(3 - pick);
				end
				default: begin
					lo = exp_cnt + meas_count_t'(1 + pick);
					hi = lo + meas_count_t'(100);
				end
			endcase
			exp_in = (lo <= exp_cnt) && (exp_cnt <= hi);

			write_expect(reg_ctrl, 32'h0, 4'hf, resp_okay, "ctrl");
			axil_read(reg_status, rd, resp);
			half_period = d;
			write_expect(reg_limit_lo, axil_data_t'(lo), 4'hf, resp_okay, "limit_lo");
			write_expect(reg_limit_hi, axil_data_t'(hi), 4'hf, resp_okay, "limit_hi");
			write_expect(reg_window, axil_data_t'(wl), 4'hf, resp_okay, "window");
			write_expect(reg_ctrl, 32'h1, 4'hf, resp_okay, "ctrl");
			// the first window may span the refclk period change, so skip it
			wait_done(rd);
			wait_done(rd);
			check_flag("in_range", rd[stat_in_range_bit], exp_in);
			check_flag("out_of_range", rd[stat_out_of_range_bit], !exp_in);
			axil_read(reg_result, rd, resp);
			check_count("result", meas_count_t'(rd), exp_cnt);
			check_resp("result rresp", resp, resp_okay);
		end

		// after disable no window closes and result keeps its value
		write_expect(reg_ctrl, 32'h0, 4'hf, resp_okay, "ctrl");
		axil_read(reg_status, rd, resp);
		// a new refclk period would show up in any window that still closed
		half_period = d + 3;
		repeat (4 * (d + 3) * wl) @(posedge xcvr_clk);
		axil_read(reg_result, rd, resp);
		check_count("result", meas_count_t'(rd), exp_cnt);
		axil_read(reg_status, rd, resp);
		check_flag("status done", rd[stat_done_bit], 1'b0);

		// interrupt follows sticky done and drops after a clearing read
		half_period = 3;
		write_expect(reg_window, 32'd2, 4'hf, resp_okay, "window");
		write_expect(reg_ctrl, 32'h3, 4'hf, resp_okay, "ctrl");
		do begin
			@(negedge xcvr_clk);
		end while (!meas_irq);
		// stop new windows but keep the interrupt enabled
		write_expect(reg_ctrl, 32'h2, 4'hf, resp_okay, "ctrl");
		axil_read(reg_status, rd, resp);
		check_flag("status done", rd[stat_done_bit], 1'b1);
		axil_read(reg_status, rd, resp);
		check_flag("status done after read", rd[stat_done_bit], 1'b0);
		@(negedge xcvr_clk);
		check_flag("meas_irq", meas_irq, 1'b0);

		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: logic/freq_monitor_top.sv
////////////////////////////////////////////////////////////////////////////
// Transceiver clock frequency monitor with an AXI4-Lite register slave
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "freq_settings.svh"

module freq_monitor_top (
	input  logic                      xcvr_clk,
	input  logic                      rst,
	input  logic                      refclk,
	input  freq_regs_pkg::axil_addr_t  awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  freq_regs_pkg::axil_data_t  wdata,
	input  logic [`AXIL_DATA_W/8-1:0] wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output freq_regs_pkg::axil_resp_t  bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  freq_regs_pkg::axil_addr_t  araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output freq_regs_pkg::axil_data_t  rdata,
	output freq_regs_pkg::axil_resp_t  rresp,
	output logic                      rvalid,
	input  logic                      rready,
	output logic                      meas_irq
);

	import freq_meas_pkg::*;

	logic        ref_edge;
	logic        meas_enable;
	logic        restart;
	win_len_t    win_len;
	meas_count_t limit_lo;
	meas_count_t limit_hi;
	meas_count_t result;
	logic        meas_done;
	logic        in_range;
	logic        out_of_range;

	// refclk is only ever seen as data in the xcvr_clk domain
	refclk_edge_sampler u_sampler (
		.xcvr_clk (xcvr_clk),
		.rst      (rst),
		.refclk   (refclk),
		.ref_edge (ref_edge)
	);

	freq_window_counter u_counter (
		.xcvr_clk     (xcvr_clk),
		.rst          (rst),
		.ref_edge     (ref_edge),
		.meas_enable  (meas_enable),
		.restart      (restart),
		.win_len      (win_len),
		.limit_lo     (limit_lo),
		.limit_hi     (limit_hi),
		.result       (result),
		.meas_done    (meas_done),
		.in_range     (in_range),
		.out_of_range (out_of_range)
	);

	freq_csr_axil u_csr (
		.xcvr_clk     (xcvr_clk),
		.rst          (rst),
		.awaddr       (awaddr),
		.awvalid      (awvalid),
		.awready      (awready),
		.wdata        (wdata),
		.wstrb        (wstrb),
		.wvalid       (wvalid),
		.wready       (wready),
		.bresp        (bresp),
		.bvalid       (bvalid),
		.bready       (bready),
		.araddr       (araddr),
		.arvalid      (arvalid),
		.arready      (arready),
		.rdata        (rdata),
		.rresp        (rresp),
		.rvalid       (rvalid),
		.rready       (rready),
		.meas_enable  (meas_enable),
		.restart      (restart),
		.win_len      (win_len),
		.limit_lo     (limit_lo),
		.limit_hi     (limit_hi),
		.result       (result),
		.meas_done    (meas_done),
		.in_range     (in_range),
		.out_of_range (out_of_range),
		.meas_irq     (meas_irq)
	);

endmodule

// File: logic/freq_csr_axil.sv
////////////////////////////////////////////////////////////////////////////
// AXI4-Lite register block with control, limits, sticky status and result
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

`include "freq_settings.svh"

module freq_csr_axil (
	input  logic                        xcvr_clk,
	input  logic                        rst,
	input  freq_regs_pkg::axil_addr_t    awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  freq_regs_pkg::axil_data_t    wdata,
	input  logic [`AXIL_DATA_W/8-1:0]   wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output freq_regs_pkg::axil_resp_t    bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  freq_regs_pkg::axil_addr_t    araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output freq_regs_pkg::axil_data_t    rdata,
	output freq_regs_pkg::axil_resp_t    rresp,
	output logic                        rvalid,
	input  logic                        rready,
	output logic                        meas_enable,
	output logic                        restart,
	output freq_meas_pkg::win_len_t      win_len,
	output freq_meas_pkg::meas_count_t   limit_lo,
	output freq_meas_pkg::meas_count_t   limit_hi,
	input  freq_meas_pkg::meas_count_t   result,
	input  logic                        meas_done,
	input  logic                        in_range,
	input  logic                        out_of_range,
	output logic                        meas_irq
);

	import freq_regs_pkg::*;
	import freq_meas_pkg::*;

	logic [1:0] ctrl_q;
	logic       done_sticky;
	logic       oor_sticky;
	logic       wr_accept;
	logic       rd_accept;
	logic       wr_hit;
	logic       rd_hit;
	logic       status_rd;
	axil_data_t status_word;
	axil_data_t wr_old;
	axil_data_t wr_merged;
	axil_data_t rd_word;

	// address and data must both be present, one response at a time
	assign wr_accept = awvalid && wvalid && !bvalid;
	assign awready   = wr_accept;
	assign wready    = wr_accept;
	assign rd_accept = arvalid && !rvalid;
	assign arready   = rd_accept;

	assign meas_enable = ctrl_q[ctrl_enable_bit];
	assign status_rd   = rd_accept && (araddr == reg_status);

	always_comb begin
		status_word = '0;
		status_word[stat_done_bit] = done_sticky;
		status_word[stat_in_range_bit] = in_range;
		status_word[stat_out_of_range_bit] = oor_sticky;
	end

	// current value of the write target, so unstrobed bytes survive
	always_comb begin
		wr_hit = 1'b1;
		wr_old = '0;
		case (reg_offset_t'(awaddr))
			reg_ctrl:     wr_old = axil_data_t'(ctrl_q);
			reg_window:   wr_old = axil_data_t'(win_len);
			reg_limit_lo: wr_old = axil_data_t'(limit_lo);
			reg_limit_hi: wr_old = axil_data_t'(limit_hi);
			// status and result are read only, writes are ignored
			reg_status:   wr_old = '0;
			reg_result:   wr_old = '0;
			default:      wr_hit = 1'b0;
		endcase
		wr_merged = wr_old;
		for (int i = 0; i < `AXIL_DATA_W / 8; i++) begin
			if (wstrb[i]) begin
				wr_merged[i*8 +: 8] = wdata[i*8 +: 8];
			end
		end
	end

	always_comb begin
		rd_hit  = 1'b1;
		rd_word = '0;
		case (reg_offset_t'(araddr))
			reg_ctrl:     rd_word = axil_data_t'(ctrl_q);
			reg_window:   rd_word = axil_data_t'(win_len);
			reg_limit_lo: rd_word = axil_data_t'(limit_lo);
			reg_limit_hi: rd_word = axil_data_t'(limit_hi);
			reg_status:   rd_word = status_word;
			reg_result:   rd_word = axil_data_t'(result);
			default:      rd_hit  = 1'b0;
		endcase
	end

	// write channel and the writable registers
	always_ff @(posedge xcvr_clk or posedge rst) begin
		if (rst) begin
			ctrl_q   <= '0;
			win_len  <= win_len_t'(`FREQ_WIN_DEFAULT);
			limit_lo <= '0;
			limit_hi <= meas_count_max;
			restart  <= 1'b0;
			bvalid   <= 1'b0;
			bresp    <= resp_okay;
		end else begin
			restart <= 1'b0;
			if (wr_accept) begin
				bvalid <= 1'b1;
				bresp  <= wr_hit ? resp_okay : resp_slverr;
				case (reg_offset_t'(awaddr))
					reg_ctrl: begin
						ctrl_q  <= wr_merged[1:0];
						restart <= 1'b1;
					end
					reg_window: begin
						win_len <= win_len_t'(wr_merged);
						restart <= 1'b1;
					end
					reg_limit_lo: limit_lo <= meas_count_t'(wr_merged);
					reg_limit_hi: limit_hi <= meas_count_t'(wr_merged);
					default: ;
				endcase
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// read channel, data is captured when the address is taken
	always_ff @(posedge xcvr_clk or posedge rst) begin
		if (rst) begin
			rvalid <= 1'b0;
			rdata  <= '0;
			rresp  <= resp_okay;
		end else begin
			if (rd_accept) begin
				rvalid <= 1'b1;
				rdata  <= rd_word;
				rresp  <= rd_hit ? resp_okay : resp_slverr;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	// sticky status, cleared by a status read unless a window ends then
	always_ff @(posedge xcvr_clk or posedge rst) begin
		if (rst) begin
			done_sticky <= 1'b0;
			oor_sticky  <= 1'b0;
			meas_irq    <= 1'b0;
		end else begin
			done_sticky <= meas_done | (done_sticky & ~status_rd);
			oor_sticky  <= (meas_done & out_of_range) | (oor_sticky & ~status_rd);
			meas_irq    <= done_sticky & ctrl_q[ctrl_irq_en_bit];
		end
	end

endmodule

// File: logic/freq_window_counter.sv
////////////////////////////////////////////////////////////////////////////
// Window timer and xcvr_clk cycle counter with result latch and limit check
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module freq_window_counter (
	input  logic                      xcvr_clk,
	input  logic                      rst,
	input  logic                      ref_edge,
	input  logic                      meas_enable,
	input  logic                      restart,
	input  freq_meas_pkg::win_len_t    win_len,
	input  freq_meas_pkg::meas_count_t limit_lo,
	input  freq_meas_pkg::meas_count_t limit_hi,
	output freq_meas_pkg::meas_count_t result,
	output logic                      meas_done,
	output logic                      in_range,
	output logic                      out_of_range
);

	import freq_meas_pkg::*;

	typedef enum logic {
		st_wait,
		st_count
	} state_t;

	state_t      state;
	win_len_t    edge_cnt;
	win_len_t    win_last;
	meas_count_t cyc_cnt;
	meas_count_t cyc_next;
	logic        win_close;
	logic        cnt_fits;

	// index of the closing edge, a zero length acts as one edge
	assign win_last = (win_len == '0) ? '0 : win_len - 1'b1;

	// count including the current cycle, held at the top once it gets there
	assign cyc_next = (cyc_cnt == meas_count_max) ? cyc_cnt : cyc_cnt + 1'b1;

	// the edge that ends the window also starts the next one
	assign win_close = (state == st_count) && ref_edge && (edge_cnt == win_last);

	// limits are inclusive at both ends
	assign cnt_fits = (cyc_next >= limit_lo) && (cyc_next <= limit_hi);

	always_ff @(posedge xcvr_clk or posedge rst) begin
		if (rst) begin
			state        <= st_wait;
			edge_cnt     <= '0;
			cyc_cnt      <= '0;
			result       <= '0;
			meas_done    <= 1'b0;
			in_range     <= 1'b0;
			out_of_range <= 1'b0;
		end else begin
			meas_done <= 1'b0;
			if (!meas_enable || restart) begin
				// result and flags keep their last values while idle
				state <= st_wait;
			end else if (state == st_wait) begin
				// first edge after enable opens the window
				if (ref_edge) begin
					state    <= st_count;
					edge_cnt <= '0;
					cyc_cnt  <= '0;
				end
			end else begin
				cyc_cnt <= cyc_next;
				if (win_close) begin
					result       <= cyc_next;
					meas_done    <= 1'b1;
					in_range     <= cnt_fits;
					out_of_range <= !cnt_fits;
					// restart at once so measurement runs back to back
					edge_cnt     <= '0;
					cyc_cnt      <= '0;
				end else if (ref_edge) begin
					edge_cnt <= edge_cnt + 1'b1;
				end
			end
		end
	end

endmodule

// File: logic/refclk_edge_sampler.sv
////////////////////////////////////////////////////////////////////////////
// Reference clock sampler giving one xcvr_clk pulse per refclk rising edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module refclk_edge_sampler (
	input  logic xcvr_clk,
	input  logic rst,
	input  logic refclk,
	output logic ref_edge
);

	// two stage synchronizer, then the previous synchronized level
	logic sync_q1;
	logic sync_q2;
	logic prev_q;

	always_ff @(posedge xcvr_clk or posedge rst) begin
		if (rst) begin
			sync_q1  <= 1'b0;
			sync_q2  <= 1'b0;
			prev_q   <= 1'b0;
			ref_edge <= 1'b0;
		end else begin
			sync_q1 <= refclk;
			sync_q2 <= sync_q1;
			prev_q  <= sync_q2;
			// a low to high step of the synchronized level is one edge,
			// so the duty cycle of refclk does not matter
			ref_edge <= sync_q2 & ~prev_q;
		end
	end

endmodule

// File: logic/freq_regs_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Register map and AXI4-Lite encodings for the frequency monitor
////////////////////////////////////////////////////////////////////////////

`include "freq_settings.svh"

package freq_regs_pkg;

	typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
	typedef logic [`AXIL_DATA_W-1:0] axil_data_t;

	// only the two responses this slave can give
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_slverr = 2'b10
	} axil_resp_t;

	// byte offsets of the registers, anything else is unmapped
	typedef enum logic [`AXIL_ADDR_W-1:0] {
		reg_ctrl     = 'h00,
		reg_window   = 'h04,
		reg_limit_lo = 'h08,
		reg_limit_hi = 'h0c,
		reg_status   = 'h10,
		reg_result   = 'h14
	} reg_offset_t;

	// control register bits
	localparam int unsigned ctrl_enable_bit = 0;
	localparam int unsigned ctrl_irq_en_bit = 1;

	// status register bits
	localparam int unsigned stat_done_bit         = 0;
	localparam int unsigned stat_in_range_bit     = 1;
	localparam int unsigned stat_out_of_range_bit = 2;

endpackage

// File: logic/freq_meas_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Measurement types shared by the window counter and the register block
////////////////////////////////////////////////////////////////////////////

`include "freq_settings.svh"

package freq_meas_pkg;

	// number of xcvr_clk cycles seen inside one measurement window
	typedef logic [`FREQ_CNT_W-1:0] meas_count_t;

	// window length, counted in reference clock rising edges
	// a value of zero behaves as a window of one edge
	typedef logic [`FREQ_WIN_W-1:0] win_len_t;

	// the count sticks here instead of wrapping when the reference is lost
	localparam meas_count_t meas_count_max = '1;

endpackage

// File: logic/freq_settings.svh
////////////////////////////////////////////////////////////////////////////
// Frequency monitor build settings for counter, window and bus widths
////////////////////////////////////////////////////////////////////////////

`ifndef FREQ_SETTINGS_SVH
`define FREQ_SETTINGS_SVH

// xcvr_clk cycles counted over one window, saturating at the top
`define FREQ_CNT_W 24

// window length in reference clock edges
`define FREQ_WIN_W 16

// window length loaded by reset, before software touches the register
`define FREQ_WIN_DEFAULT 16

// register bus widths, byte addressed
`define AXIL_ADDR_W 8
`define AXIL_DATA_W 32

`endif
